/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_bridge
FILELIST = list.f
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* list.f */
verilog/bridge_pkg.sv
verilog/ctrl_regs.sv
verilog/dram_rebase_stage.sv
verilog/dram_check_stage.sv
verilog/zynq_dram_bridge.sv
tests/tb_bridge.sv

/* tests/bridge_testdata.txt */
# T name | W addr data err | R addr data err | Q addr write (memaddr or rej)
# P backpressure(0/1) | C core_reset_n | D drain the request pipeline
T reset
C 0
R 00 00000000 0
R 04 00000000 0
R 08 00000000 0
R 0C 00000000 0
R 10 00000000 0
R 14 00000000 0
R 18 00000000 0
R 1C 00000000 0
T regs
W 00 00000003 0
R 00 00000001 0
C 1
W 04 ffffffff 0
R 04 00000001 0
W 08 10000000 0
R 08 10000000 0
R 20 00000000 1
W 0C 12345678 1
W 1C 00000001 1
W 3C 00000000 1
R 0C 00000000 0
T rebase
P 0
Q 80000000 0 10000000
Q 80001000 1 10001000
Q 80800040 0 10800040
Q 81000000 1 11000000
D
T backpressure
P 1
Q 80000000 0 10000000
Q 80001000 1 10001000
Q 80800040 0 10800040
Q 81000000 1 11000000
D
P 0
R 0C 00000007 0
R 1C 00000000 0
T bounds
W 00 00000000 0
C 0
R 0C 00000000 0
W 00 00000001 0
C 1
Q 80000000 1 10000000
Q 82000100 0 12000100
Q 86ffff00 1 16ffff00
Q 87800000 0 rej
Q 877ffffc 0 177ffffc
Q 90000000 1 rej
Q 00000000 0 rej
D
R 1C 00000003 0
R 0C 00006011 0
R 10 00000000 0
R 14 00000000 0
R 18 00000000 0
T run_clear
W 00 00000000 0
C 0
R 0C 00000000 0
R 1C 00000000 0
R 04 00000001 0
W 00 00000001 0
W 08 20000000 0
Q 80000010 0 20000010
D
R 0C 00000001 0

/* tests/tb_bridge.sv */
module tb_bridge;
   timeunit 1ns;
   timeprecision 1ps;

   import bridge_pkg::*;

   // cycles any single wait may take before the run is abandoned
   localparam int wait_limit = 200;

   logic        aclk_i = 1'b0;
   logic        rst_n_i;
   logic        psel_i;
   logic        penable_i;
   logic        pwrite_i;
   csr_addr_t   paddr_i;
   word_t       pwdata_i;
   word_t       prdata_o;
   logic        pready_o;
   logic        pslverr_o;
   logic        req_valid_i;
   dram_req_t   req_i;
   logic        req_ready_o;
   logic        mem_valid_o;
   dram_req_t   mem_req_o;
   logic        mem_ready_i = 1'b1;
   logic        core_reset_n_o;

   dram_req_t   exp_q[$];
   dram_req_t   mon_exp;
   logic [31:0] rng_state = 32'd30746;
   logic        bp_mode = 1'b0;
   logic        aborted = 1'b0;
   logic        in_test = 1'b0;
   string       test_label = "none";
   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   int          test_errors = 0;
   int          test_checks = 0;

   zynq_dram_bridge uut
     (
      .aclk_i         (aclk_i),
      .rst_n_i        (rst_n_i),
      .psel_i         (psel_i),
      .penable_i      (penable_i),
      .pwrite_i       (pwrite_i),
      .paddr_i        (paddr_i),
      .pwdata_i       (pwdata_i),
      .prdata_o       (prdata_o),
      .pready_o       (pready_o),
      .pslverr_o      (pslverr_o),
      .req_valid_i    (req_valid_i),
      .req_i          (req_i),
      .req_ready_o    (req_ready_o),
      .mem_valid_o    (mem_valid_o),
      .mem_req_o      (mem_req_o),
      .mem_ready_i    (mem_ready_i),
      .core_reset_n_o (core_reset_n_o)
      );

   always #10 aclk_i = !aclk_i;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // memory-side ready is either held high or toggled by the generator
   always @(negedge aclk_i)
   begin
      rng_state = lcg_next(rng_state);
      if (bp_mode)
         mem_ready_i = rng_state[16];
      else
         mem_ready_i = 1'b1;
   end

   task automatic check_word(input string what, input word_t exp, input word_t act);
      checks++;
      test_checks++;
      if (exp !== act)
      begin
         errors++;
         test_errors++;
         $display("Fail %0s %0s: expected %h, actual %h", test_label, what, exp, act);
      end
   endtask

   task automatic check_req(input string what, input dram_req_t exp, input dram_req_t act);
      checks++;
      test_checks++;
      if (exp !== act)
      begin
         errors++;
         test_errors++;
         $display("Fail %0s %0s: expected addr %h write %b, actual addr %h write %b",
                  test_label, what, exp.addr, exp.write, act.addr, act.write);
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      checks++;
      test_checks++;
      if (exp !== act)
      begin
         errors++;
         test_errors++;
         $display("Fail %0s %0s: expected %b, actual %b", test_label, what, exp, act);
      end
   endtask

   // every transfer on the memory side must match the oldest expected request
   always @(posedge aclk_i)
   begin
      if (rst_n_i && mem_valid_o && mem_ready_i)
      begin
         if (exp_q.size() == 0)
         begin
            errors++;
            test_errors++;
            $display("%0s: a request reached memory that should have been rejected",
                     test_label);
         end
         else
         begin
            mon_exp = exp_q.pop_front();
            check_req("memory request", mon_exp, mem_req_o);
         end
      end
   end

   task automatic apb_access(input logic wr, input csr_addr_t addr, input word_t wdata,
                             output word_t rdata, output logic err);
      int waited;
      waited = 0;
      @(negedge aclk_i);
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = wr;
      paddr_i   = addr;
      pwdata_i  = wdata;
      @(negedge aclk_i);
      penable_i = 1'b1;
      @(posedge aclk_i);
      while (!pready_o && waited < wait_limit)
      begin
         @(posedge aclk_i);
         waited++;
      end
      if (!pready_o)
      begin
         $display("timeout: APB access to offset %h never completed", addr);
         aborted = 1'b1;
      end
      rdata = prdata_o;
      err   = pslverr_o;
      @(negedge aclk_i);
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
   endtask

   task automatic send_request(input dram_req_t req);
      int waited;
      waited = 0;
      @(negedge aclk_i);
      req_valid_i = 1'b1;
      req_i       = req;
      @(posedge aclk_i);
      while (!req_ready_o && waited < wait_limit)
      begin
         @(posedge aclk_i);
         waited++;
      end
      if (!req_ready_o)
      begin
         $display("timeout: core request to %h was never accepted", req.addr);
         aborted = 1'b1;
      end
      @(negedge aclk_i);
      req_valid_i = 1'b0;
   endtask

   // wait until both stages are empty and every expected request has left
   task automatic drain_pipeline;
      int waited;
      waited = 0;
      @(negedge aclk_i);
      while ((exp_q.size() != 0 || uut.s1_valid || mem_valid_o) && waited < wait_limit)
      begin
         @(negedge aclk_i);
         waited++;
      end
      if (exp_q.size() != 0 || uut.s1_valid || mem_valid_o)
      begin
         $display("timeout: %0d expected requests never reached memory", exp_q.size());
         aborted = 1'b1;
      end
   endtask

   task automatic finish_test;
      if (in_test)
      begin
         $display("test %0s: %0d checks, %0d errors", test_label, test_checks, test_errors);
      end
      in_test = 1'b0;
   endtask

   initial
   begin
      int                fd;
      int                r;
      logic [8*8-1:0]    op;
      logic [8*32-1:0]   name_raw;
      logic [8*16-1:0]   tok;
      logic [8*128-1:0]  line;
      logic [31:0]       a_f;
      logic [31:0]       d_f;
      logic [31:0]       e_f;
      logic [31:0]       m_f;
      word_t             rdata;
      logic              err;
      dram_req_t         req;
      dram_req_t         exp;

      rst_n_i     = 1'b0;
      psel_i      = 1'b0;
      penable_i   = 1'b0;
      pwrite_i    = 1'b0;
      paddr_i     = '0;
      pwdata_i    = '0;
      req_valid_i = 1'b0;
      req_i       = '0;
      repeat (2) @(posedge aclk_i);
      @(negedge aclk_i);
      rst_n_i = 1'b1;

      fd = $fopen("tests/bridge_testdata.txt", "r");
      if (fd == 0)
      begin
         $display("could not open tests/bridge_testdata.txt");
         aborted = 1'b1;
      end

      while (!aborted && fd != 0 && $fscanf(fd, "%s", op) == 1)
      begin
         if (op == "#")
         begin
            r = $fgets(line, fd);
         end
         else if (op == "T")
         begin
            finish_test();
            r = $fscanf(fd, "%s", name_raw);
            test_label  = $sformatf("%0s", name_raw);
            test_checks = 0;
            test_errors = 0;
            in_test     = 1'b1;
            tests++;
         end
         else if (op == "W")
         begin
            r = $fscanf(fd, "%h %h %h", a_f, d_f, e_f);
            apb_access(1'b1, a_f[5:0], d_f, rdata, err);
            check_bit($sformatf("write error at %h", a_f[5:0]), e_f[0], err);
         end
         else if (op == "R")
         begin
            r = $fscanf(fd, "%h %h %h", a_f, d_f, e_f);
            apb_access(1'b0, a_f[5:0], '0, rdata, err);
            check_word($sformatf("read data at %h", a_f[5:0]), d_f, rdata);
            check_bit($sformatf("read error at %h", a_f[5:0]), e_f[0], err);
         end
         else if (op == "Q")
         begin
            r = $fscanf(fd, "%h %h %s", a_f, d_f, tok);
            req.addr  = a_f;
            req.write = d_f[0];
            if (tok != "rej")
            begin
               r = $sscanf(tok, "%h", m_f);
               exp.addr  = m_f;
               exp.write = d_f[0];
               exp_q.push_back(exp);
            end
            send_request(req);
         end
         else if (op == "P")
         begin
            r = $fscanf(fd, "%h", e_f);
            @(posedge aclk_i);
            bp_mode = e_f[0];
         end
         else if (op == "C")
         begin
            r = $fscanf(fd, "%h", e_f);
            @(negedge aclk_i);
            check_bit("core reset", e_f[0], core_reset_n_o);
         end
         else if (op == "D")
         begin
            drain_pipeline();
         end
         else
         begin
            $display("unknown operation %0s in the test data file", op);
            aborted = 1'b1;
         end
      end
      finish_test();
      if (fd != 0)
         $fclose(fd);

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0 && !aborted && tests > 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

/* verilog/bridge_pkg.sv */
package bridge_pkg;

   // byte address on either the core side or the host DRAM side
   typedef logic [31:0] addr_t;

   // one APB data word
   typedef logic [31:0] word_t;

   // byte offset into the control register block
   typedef logic [5:0] csr_addr_t;

   // usage profile with one bit per DRAM region
   typedef logic [127:0] region_map_t;

   // number of requests dropped by the bounds check
   typedef logic [31:0] count_t;

   // a DRAM request as it leaves the core and as it reaches memory
   typedef struct packed
   {
      addr_t addr;
      logic  write;
   } dram_req_t;

   // the rebase stage hands the check stage both the rebased request and
   // the window offset, so the bounds check needs no second subtraction
   typedef struct packed
   {
      dram_req_t req;
      addr_t     offset;
   } stage_req_t;

   // base of the core's cached DRAM window
   localparam addr_t bp_dram_base = 32'h8000_0000;

   // regions tracked by the usage profile
   localparam int num_regions = 128;

endpackage

/* verilog/ctrl_regs.sv */
module ctrl_regs
  (
   input  logic                   aclk_i,
   input  logic                   rst_n_i,

   input  logic                   psel_i,
   input  logic                   penable_i,
   input  logic                   pwrite_i,
   input  bridge_pkg::csr_addr_t  paddr_i,
   input  bridge_pkg::word_t      pwdata_i,
   output bridge_pkg::word_t      prdata_o,
   output logic                   pready_o,
   output logic                   pslverr_o,

   input  bridge_pkg::region_map_t region_map_i,
   input  bridge_pkg::count_t     reject_count_i,

   output logic                   core_run_o,
   output bridge_pkg::addr_t      dram_base_o
   );

   import bridge_pkg::*;

   // register map in byte offsets
   localparam csr_addr_t run_addr   = 6'h00;
   localparam csr_addr_t alloc_addr = 6'h04;
   localparam csr_addr_t base_addr  = 6'h08;
   localparam csr_addr_t prof0_addr = 6'h0C;
   localparam csr_addr_t prof1_addr = 6'h10;
   localparam csr_addr_t prof2_addr = 6'h14;
   localparam csr_addr_t prof3_addr = 6'h18;
   localparam csr_addr_t count_addr = 6'h1C;

   logic  run_r;
   logic  alloc_r;
   addr_t base_r;

   word_t rd_data;
   logic  mapped;
   logic  read_only;
   logic  access;
   logic  wr_en;

   // the access phase is the second cycle of every APB transfer
   assign access = psel_i && penable_i;

   always_comb
   begin
      rd_data   = '0;
      mapped    = 1'b1;
      read_only = 1'b0;
      case (paddr_i)
         run_addr:   rd_data = {31'b0, run_r};
         alloc_addr: rd_data = {31'b0, alloc_r};
         base_addr:  rd_data = base_r;
         prof0_addr:
         begin
            rd_data   = region_map_i[31:0];
            read_only = 1'b1;
         end
         prof1_addr:
         begin
            rd_data   = region_map_i[63:32];
            read_only = 1'b1;
         end
         prof2_addr:
         begin
            rd_data   = region_map_i[95:64];
            read_only = 1'b1;
         end
         prof3_addr:
         begin
            rd_data   = region_map_i[127:96];
            read_only = 1'b1;
         end
         count_addr:
         begin
            rd_data   = reject_count_i;
            read_only = 1'b1;
         end
         default:    mapped = 1'b0;
      endcase
   end

   // a write that errors leaves every register untouched
   assign wr_en = access && pwrite_i && mapped && !read_only;

   always_ff @(posedge aclk_i)
   begin
      if (!rst_n_i)
      begin
         run_r   <= 1'b0;
         alloc_r <= 1'b0;
         base_r  <= '0;
      end
      else if (wr_en)
      begin
         case (paddr_i)
            run_addr:   run_r   <= pwdata_i[0];
            alloc_addr: alloc_r <= pwdata_i[0];
            base_addr:  base_r  <= pwdata_i;
            default:    ;
         endcase
      end
   end

   assign prdata_o  = rd_data;
   assign pready_o  = 1'b1;
   assign pslverr_o = access && (!mapped || (pwrite_i && read_only));

   // the core is held in reset until the host sets the run bit
   assign core_run_o  = run_r;
   assign dram_base_o = base_r;

   // a write the host sees rejected must not have changed any stored register
   err_write_ignored: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      pslverr_o && pwrite_i |=> $stable(run_r) && $stable(alloc_r) && $stable(base_r));

endmodule

/* verilog/dram_check_stage.sv */
module dram_check_stage
  #(
   parameter bridge_pkg::addr_t mem_limit_p    = 32'd125829120,
   parameter int                region_shift_p = 23
   )
  (
   input  logic                    aclk_i,
   input  logic                    rst_n_i,
   input  logic                    core_run_i,

   input  logic                    in_valid_i,
   input  bridge_pkg::stage_req_t  in_req_i,
   output logic                    in_ready_o,

   output logic                    out_valid_o,
   output bridge_pkg::dram_req_t   out_req_o,
   input  logic                    out_ready_i,

   output bridge_pkg::region_map_t region_map_o,
   output bridge_pkg::count_t      reject_count_o
   );

   import bridge_pkg::*;

   localparam int region_idx_w = $clog2(num_regions);

   logic                    valid_r;
   dram_req_t               req_r;
   region_map_t             map_r;
   count_t                  count_r;

   logic                    take;
   logic                    in_range;
   logic                    forward;
   logic                    reject;
   logic [region_idx_w-1:0] region_idx;

   assign in_ready_o = !valid_r || out_ready_i;
   assign take       = in_valid_i && in_ready_o;

   assign in_range = in_req_i.offset < mem_limit_p;
   assign forward  = take && in_range;
   assign reject   = take && !in_range;

   // offsets past the last region wrap back into the bitmap
   assign region_idx = region_idx_w'(in_req_i.offset >> region_shift_p);

   // rejected requests are consumed here and leave the stage empty
   always_ff @(posedge aclk_i)
   begin
      if (!rst_n_i)
      begin
         valid_r <= 1'b0;
      end
      else if (in_ready_o)
      begin
         valid_r <= forward;
      end
   end

   always_ff @(posedge aclk_i)
   begin
      if (forward)
      begin
         req_r <= in_req_i.req;
      end
   end

   // profile and count restart each time the host stops the core
   always_ff @(posedge aclk_i)
   begin
      if (!rst_n_i || !core_run_i)
      begin
         map_r   <= '0;
         count_r <= '0;
      end
      else
      begin
         if (forward)
         begin
            map_r[region_idx] <= 1'b1;
         end
         if (reject)
         begin
            count_r <= count_r + count_t'(1);
         end
      end
   end

   assign out_valid_o    = valid_r;
   assign out_req_o      = req_r;
   assign region_map_o   = map_r;
   assign reject_count_o = count_r;

   // a request past the limit never reaches memory, and it is counted instead
   reject_dropped: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      reject && core_run_i |=> !out_valid_o && (reject_count_o == $past(count_r) + 1));

endmodule

/* verilog/dram_rebase_stage.sv */
module dram_rebase_stage
  (
   input  logic                   aclk_i,
   input  logic                   rst_n_i,

   input  logic                   in_valid_i,
   input  bridge_pkg::dram_req_t  in_req_i,
   output logic                   in_ready_o,

   input  bridge_pkg::addr_t      dram_base_i,

   output logic                   out_valid_o,
   output bridge_pkg::stage_req_t out_req_o,
   input  logic                   out_ready_i
   );

   import bridge_pkg::*;

   logic       valid_r;
   stage_req_t req_r;
   addr_t      offset;
   logic       take;

   // the window base is a single high bit, so xor strips it like a subtraction
   assign offset = in_req_i.addr ^ bp_dram_base;

   // accept when empty or when the held request leaves this cycle
   assign in_ready_o = !valid_r || out_ready_i;
   assign take       = in_valid_i && in_ready_o;

   always_ff @(posedge aclk_i)
   begin
      if (!rst_n_i)
      begin
         valid_r <= 1'b0;
      end
      else if (in_ready_o)
      begin
         valid_r <= in_valid_i;
      end
   end

   always_ff @(posedge aclk_i)
   begin
      if (take)
      begin
         req_r.offset    <= offset;
         req_r.req.addr  <= offset + dram_base_i;
         req_r.req.write <= in_req_i.write;
      end
   end

   assign out_valid_o = valid_r;
   assign out_req_o   = req_r;

   // the check stage may stall, and the request it sees must not change meanwhile
   stall_stable: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_req_o));

endmodule

/* verilog/zynq_dram_bridge.sv */
module zynq_dram_bridge
  #(
   parameter bridge_pkg::addr_t mem_limit_p    = 32'd125829120,
   parameter int                region_shift_p = 23
   )
  (
   input  logic                  aclk_i,
   input  logic                  rst_n_i,

   // host register access
   input  logic                  psel_i,
   input  logic                  penable_i,
   input  logic                  pwrite_i,
   input  bridge_pkg::csr_addr_t paddr_i,
   input  bridge_pkg::word_t     pwdata_i,
   output bridge_pkg::word_t     prdata_o,
   output logic                  pready_o,
   output logic                  pslverr_o,

   // DRAM requests from the core
   input  logic                  req_valid_i,
   input  bridge_pkg::dram_req_t req_i,
   output logic                  req_ready_o,

   // rebased requests toward host DRAM
   output logic                  mem_valid_o,
   output bridge_pkg::dram_req_t mem_req_o,
   input  logic                  mem_ready_i,

   output logic                  core_reset_n_o
   );

   import bridge_pkg::*;

   logic        core_run;
   addr_t       dram_base;
   region_map_t region_map;
   count_t      reject_count;

   logic        s1_valid;
   stage_req_t  s1_req;
   logic        s1_ready;

   ctrl_regs regs
     (
      .aclk_i         (aclk_i),
      .rst_n_i        (rst_n_i),
      .psel_i         (psel_i),
      .penable_i      (penable_i),
      .pwrite_i       (pwrite_i),
      .paddr_i        (paddr_i),
      .pwdata_i       (pwdata_i),
      .prdata_o       (prdata_o),
      .pready_o       (pready_o),
      .pslverr_o      (pslverr_o),
      .region_map_i   (region_map),
      .reject_count_i (reject_count),
      .core_run_o     (core_run),
      .dram_base_o    (dram_base)
      );

   dram_rebase_stage rebase
     (
      .aclk_i      (aclk_i),
      .rst_n_i     (rst_n_i),
      .in_valid_i  (req_valid_i),
      .in_req_i    (req_i),
      .in_ready_o  (req_ready_o),
      .dram_base_i (dram_base),
      .out_valid_o (s1_valid),
      .out_req_o   (s1_req),
      .out_ready_i (s1_ready)
      );

   dram_check_stage
     #(
      .mem_limit_p    (mem_limit_p),
      .region_shift_p (region_shift_p)
      )
   check
     (
      .aclk_i         (aclk_i),
      .rst_n_i        (rst_n_i),
      .core_run_i     (core_run),
      .in_valid_i     (s1_valid),
      .in_req_i       (s1_req),
      .in_ready_o     (s1_ready),
      .out_valid_o    (mem_valid_o),
      .out_req_o      (mem_req_o),
      .out_ready_i    (mem_ready_i),
      .region_map_o   (region_map),
      .reject_count_o (reject_count)
      )
   ;

   // the run bit doubles as the core's reset, so a program can be rerun
   // without reloading the bitstream
   assign core_reset_n_o = core_run;

endmodule
